/* include/exu_defines.svh */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data and pc width, RV64 only
`define EXU_XLEN 64

// machine mode CSR addresses
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

// mcause code for ecall from machine mode
`define EXU_CAUSE_ECALL_M 11

`endif

/* hdl/exu_op_pkg.sv */
package exu_op_pkg;

	// decoded opcodes seen by the execute stage
	typedef enum logic [5:0] {
		op_add, op_sub, op_addw, op_subw,
		op_slt, op_sltu, op_xor, op_or, op_and,
		op_sll, op_srl, op_sra, op_sllw, op_srlw, op_sraw,
		op_link,
		op_mul, op_mulh, op_mulhu, op_mulhsu, op_mulw,
		op_div, op_divu, op_divw, op_divuw,
		op_rem, op_remu, op_remw, op_remuw,
		op_csrrw, op_csrrs, op_csrrc, op_ecall, op_mret,
		op_nop
	} exu_op_e;

	// which unit produces the result
	typedef enum logic [2:0] {
		cls_alu, cls_mul, cls_div, cls_csr, cls_nop
	} op_class_e;

	function automatic op_class_e op_class(input exu_op_e op);
		case (op)
			op_mul, op_mulh, op_mulhu, op_mulhsu, op_mulw:
				return cls_mul;
			op_div, op_divu, op_divw, op_divuw,
			op_rem, op_remu, op_remw, op_remuw:
				return cls_div;
			op_csrrw, op_csrrs, op_csrrc, op_ecall, op_mret:
				return cls_csr;
			op_nop:
				return cls_nop;
			default:
				return cls_alu;
		endcase
	endfunction

endpackage

/* hdl/exu_csr_pkg.sv */
package exu_csr_pkg;

	// command to the CSR file, valid for one cycle
	// none   no access, rdata still follows addr
	// write  replace the register
	// set    OR wdata into the register
	// clear  remove wdata bits from the register
	// ecall  trap entry, mepc and mcause updated
	// mret   trap return, only selects mepc as target
	typedef enum logic [2:0] {
		csr_none,
		csr_write,
		csr_set,
		csr_clear,
		csr_ecall,
		csr_mret
	} csr_cmd_e;

endpackage

/* hdl/muldiv_if.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

// one request and one response to an iterative unit
interface muldiv_if;

	// request side
	logic                 start;
	logic [`EXU_XLEN-1:0] op1;
	logic [`EXU_XLEN-1:0] op2;
	// mul: bit 1 op1 signed, bit 0 op2 signed
	// div: bit 0 signed, bit 1 unused
	logic [1:0]           sgn;
	logic                 word;

	// response side, div returns remainder in hi and quotient in lo
	logic                 busy;
	logic                 done;
	logic [`EXU_XLEN-1:0] res_hi;
	logic [`EXU_XLEN-1:0] res_lo;

	modport ctrl (output start, op1, op2, sgn, word, input busy, done, res_hi, res_lo);
	modport unit (input start, op1, op2, sgn, word, output busy, done, res_hi, res_lo);

endinterface

/* hdl/exu_alu.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_alu (
	input exu_op_pkg::exu_op_e   op,
	input logic [`EXU_XLEN-1:0]  op1,
	input logic [`EXU_XLEN-1:0]  op2,
	input logic [`EXU_XLEN-1:0]  pc,
	output logic [`EXU_XLEN-1:0] res
);

	logic [31:0] addw;
	logic [31:0] subw;
	logic [31:0] sllw;
	logic [31:0] srlw;
	logic [31:0] sraw;
	logic        lt_s;
	logic        lt_u;

	// word forms work on the low half, shift amount is 5 bits
	assign addw = op1[31:0] + op2[31:0];
	assign subw = op1[31:0] - op2[31:0];
	assign sllw = op1[31:0] << op2[4:0];
	assign srlw = op1[31:0] >> op2[4:0];
	assign sraw = $signed(op1[31:0]) >>> op2[4:0];

	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	always_comb begin
		case (op)
			exu_op_pkg::op_add:  res = op1 + op2;
			exu_op_pkg::op_sub:  res = op1 - op2;
			exu_op_pkg::op_xor:  res = op1 ^ op2;
			exu_op_pkg::op_or:   res = op1 | op2;
			exu_op_pkg::op_and:  res = op1 & op2;
			exu_op_pkg::op_slt:  res = `EXU_XLEN'(lt_s);
			exu_op_pkg::op_sltu: res = `EXU_XLEN'(lt_u);
			exu_op_pkg::op_sll:  res = op1 << op2[5:0];
			exu_op_pkg::op_srl:  res = op1 >> op2[5:0];
			exu_op_pkg::op_sra:  res = $signed(op1) >>> op2[5:0];
			// 32-bit results are sign-extended
			exu_op_pkg::op_addw: res = {{(`EXU_XLEN-32){addw[31]}}, addw};
			exu_op_pkg::op_subw: res = {{(`EXU_XLEN-32){subw[31]}}, subw};
			exu_op_pkg::op_sllw: res = {{(`EXU_XLEN-32){sllw[31]}}, sllw};
			exu_op_pkg::op_srlw: res = {{(`EXU_XLEN-32){srlw[31]}}, srlw};
			exu_op_pkg::op_sraw: res = {{(`EXU_XLEN-32){sraw[31]}}, sraw};
			// return address for jal and jalr
			exu_op_pkg::op_link: res = pc + `EXU_XLEN'd4;
			default:             res = '0;
		endcase
	end

endmodule

/* hdl/exu_multiplier.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_multiplier (
	input logic    clk,
	input logic    reset,
	muldiv_if.unit mul
);

	logic                   op1_neg;
	logic                   op2_neg;
	logic [`EXU_XLEN-1:0]   op1_mag;
	logic [`EXU_XLEN-1:0]   op2_mag;
	logic [`EXU_XLEN-1:0]   mcand;
	logic [2*`EXU_XLEN-1:0] acc;
	logic [2*`EXU_XLEN-1:0] acc_first;
	logic [2*`EXU_XLEN-1:0] acc_next;
	logic [2*`EXU_XLEN-1:0] prod;
	logic                   neg_r;
	logic                   run;
	logic [5:0]             cnt;

	// one radix-2 step adds the multiplicand into the upper half when the lsb is set
	// and shifts right
	function automatic logic [2*`EXU_XLEN-1:0] add_shift(
		input logic [2*`EXU_XLEN-1:0] a,
		input logic [`EXU_XLEN-1:0]   m
	);
		logic [`EXU_XLEN:0] sum;
		sum = {1'b0, a[2*`EXU_XLEN-1:`EXU_XLEN]} + (a[0] ? {1'b0, m} : '0);
		return {sum, a[`EXU_XLEN-1:1]};
	endfunction

	// magnitudes per operand signedness
	assign op1_neg = mul.sgn[1] & mul.op1[`EXU_XLEN-1];
	assign op2_neg = mul.sgn[0] & mul.op2[`EXU_XLEN-1];
	assign op1_mag = op1_neg ? -mul.op1 : mul.op1;
	assign op2_mag = op2_neg ? -mul.op2 : mul.op2;

	// first step is taken on the start edge
	assign acc_first = add_shift({{`EXU_XLEN{1'b0}}, op2_mag}, op1_mag);
	assign acc_next  = add_shift(acc, mcand);
	assign prod      = neg_r ? -acc_next : acc_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			run      <= 1'b0;
			mul.busy <= 1'b0;
			mul.done <= 1'b0;
			cnt      <= '0;
		end else begin
			mul.done <= 1'b0;
			if (mul.start) begin
				run      <= 1'b1;
				mul.busy <= 1'b1;
				cnt      <= 6'd1;
			end else if (run) begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd63) begin
					run      <= 1'b0;
					mul.done <= 1'b1;
				end
			end else if (mul.done) begin
				// busy covers the done cycle
				mul.busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mul.start) begin
			acc   <= acc_first;
			mcand <= op1_mag;
			neg_r <= op1_neg ^ op2_neg;
		end else if (run) begin
			acc <= acc_next;
			if (cnt == 6'd63) begin
				mul.res_hi <= prod[2*`EXU_XLEN-1:`EXU_XLEN];
				mul.res_lo <= prod[`EXU_XLEN-1:0];
			end
		end
	end

	// done comes only after all 64 steps, with busy held the whole time
	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		mul.start |=> (mul.busy && !mul.done) [*63] ##1 (mul.busy && mul.done));

endmodule

/* hdl/exu_divider.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_divider (
	input logic    clk,
	input logic    reset,
	muldiv_if.unit div
);

	logic                   sgn;
	logic [`EXU_XLEN-1:0]   dvd_ext;
	logic [`EXU_XLEN-1:0]   dvs_ext;
	logic                   dvd_neg;
	logic                   dvs_neg;
	logic [`EXU_XLEN-1:0]   rem;
	logic [`EXU_XLEN-1:0]   quo;
	logic [`EXU_XLEN-1:0]   dvs;
	logic [`EXU_XLEN-1:0]   dvd_r;
	logic                   q_neg;
	logic                   r_neg;
	logic                   dz;
	logic                   word_r;
	logic [2*`EXU_XLEN-1:0] step;
	logic [`EXU_XLEN-1:0]   q_fin;
	logic [`EXU_XLEN-1:0]   r_fin;
	logic                   run;
	logic [5:0]             cnt;

	// word mode takes the low 32 bits, sign- or zero-extended
	function automatic logic [`EXU_XLEN-1:0] ext_op(
		input logic [`EXU_XLEN-1:0] x,
		input logic                 word,
		input logic                 s
	);
		if (!word)
			return x;
		return {{(`EXU_XLEN-32){s & x[31]}}, x[31:0]};
	endfunction

	// restoring step, returns {remainder, quotient}
	function automatic logic [2*`EXU_XLEN-1:0] div_step(
		input logic [`EXU_XLEN-1:0] r,
		input logic [`EXU_XLEN-1:0] q,
		input logic [`EXU_XLEN-1:0] d
	);
		logic [`EXU_XLEN:0]   sh;
		logic [`EXU_XLEN+1:0] diff;
		sh   = {r, q[`EXU_XLEN-1]};
		diff = {1'b0, sh} - {2'b00, d};
		if (diff[`EXU_XLEN+1])
			return {sh[`EXU_XLEN-1:0], q[`EXU_XLEN-2:0], 1'b0};
		return {diff[`EXU_XLEN-1:0], q[`EXU_XLEN-2:0], 1'b1};
	endfunction

	// setup from the request
	assign sgn     = div.sgn[0];
	assign dvd_ext = ext_op(div.op1, div.word, sgn);
	assign dvs_ext = ext_op(div.op2, div.word, sgn);
	assign dvd_neg = sgn & dvd_ext[`EXU_XLEN-1];
	assign dvs_neg = sgn & dvs_ext[`EXU_XLEN-1];

	assign step = div_step(rem, quo, dvs);

	// most negative / -1 needs no special path, magnitude 2^63 stays positive
	always_comb begin
		if (dz) begin
			q_fin = '1;
			r_fin = dvd_r;
		end else begin
			q_fin = q_neg ? -step[`EXU_XLEN-1:0] : step[`EXU_XLEN-1:0];
			r_fin = r_neg ? -step[2*`EXU_XLEN-1:`EXU_XLEN] : step[2*`EXU_XLEN-1:`EXU_XLEN];
		end
		if (word_r) begin
			q_fin = {{(`EXU_XLEN-32){q_fin[31]}}, q_fin[31:0]};
			r_fin = {{(`EXU_XLEN-32){r_fin[31]}}, r_fin[31:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			run      <= 1'b0;
			div.busy <= 1'b0;
			div.done <= 1'b0;
			cnt      <= '0;
		end else begin
			div.done <= 1'b0;
			if (div.start) begin
				run      <= 1'b1;
				div.busy <= 1'b1;
				cnt      <= '0;
			end else if (run) begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd63) begin
					run      <= 1'b0;
					div.done <= 1'b1;
				end
			end else if (div.done) begin
				div.busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (div.start) begin
			rem    <= '0;
			quo    <= dvd_neg ? -dvd_ext : dvd_ext;
			dvs    <= dvs_neg ? -dvs_ext : dvs_ext;
			dvd_r  <= dvd_ext;
			q_neg  <= dvd_neg ^ dvs_neg;
			r_neg  <= dvd_neg;
			dz     <= dvs_ext == '0;
			word_r <= div.word;
		end else if (run) begin
			rem <= step[2*`EXU_XLEN-1:`EXU_XLEN];
			quo <= step[`EXU_XLEN-1:0];
			if (cnt == 6'd63) begin
				div.res_hi <= r_fin;
				div.res_lo <= q_fin;
			end
		end
	end

endmodule

/* hdl/exu_csr_file.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_csr_file (
	input logic                  clk,
	input logic                  reset,
	input exu_csr_pkg::csr_cmd_e cmd,
	input logic [11:0]           addr,
	input logic [`EXU_XLEN-1:0]  wdata,
	input logic [`EXU_XLEN-1:0]  pc,
	output logic [`EXU_XLEN-1:0] rdata,
	output logic [`EXU_XLEN-1:0] trap_pc
);

	logic [`EXU_XLEN-1:0] mstatus;
	logic [`EXU_XLEN-1:0] mtvec;
	logic [`EXU_XLEN-1:0] mepc;
	logic [`EXU_XLEN-1:0] mcause;
	logic [`EXU_XLEN-1:0] mscratch;
	logic [`EXU_XLEN-1:0] wval;
	logic                 rmw;

	// old value, unknown addresses read zero
	always_comb begin
		case (addr)
			`EXU_CSR_MSTATUS:  rdata = mstatus;
			`EXU_CSR_MTVEC:    rdata = mtvec;
			`EXU_CSR_MEPC:     rdata = mepc;
			`EXU_CSR_MCAUSE:   rdata = mcause;
			`EXU_CSR_MSCRATCH: rdata = mscratch;
			default:           rdata = '0;
		endcase
	end

	// new value for read-modify-write
	always_comb begin
		case (cmd)
			exu_csr_pkg::csr_write: wval = wdata;
			exu_csr_pkg::csr_set:   wval = rdata | wdata;
			exu_csr_pkg::csr_clear: wval = rdata & ~wdata;
			default:                wval = rdata;
		endcase
	end

	assign rmw = (cmd == exu_csr_pkg::csr_write) || (cmd == exu_csr_pkg::csr_set) ||
		(cmd == exu_csr_pkg::csr_clear);

	// trap entry jumps to mtvec, mret returns to mepc
	assign trap_pc = (cmd == exu_csr_pkg::csr_ecall) ? mtvec : mepc;

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus  <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mscratch <= '0;
		end else if (cmd == exu_csr_pkg::csr_ecall) begin
			mepc   <= pc;
			mcause <= `EXU_XLEN'(`EXU_CAUSE_ECALL_M);
		end else if (rmw) begin
			case (addr)
				`EXU_CSR_MSTATUS:  mstatus  <= wval;
				`EXU_CSR_MTVEC:    mtvec    <= wval;
				`EXU_CSR_MEPC:     mepc     <= wval;
				`EXU_CSR_MCAUSE:   mcause   <= wval;
				`EXU_CSR_MSCRATCH: mscratch <= wval;
				default: begin
				end
			endcase
		end
	end

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_top (
	input logic                  clk,
	input logic                  reset,
	input logic                  in_valid,
	input exu_op_pkg::exu_op_e   op,
	input logic [`EXU_XLEN-1:0]  op1,
	input logic [`EXU_XLEN-1:0]  op2,
	input logic [11:0]           csr_addr,
	input logic [`EXU_XLEN-1:0]  pc,
	input logic                  ls_ready,
	output logic                 ex_ready,
	output logic                 out_valid,
	output logic [`EXU_XLEN-1:0] result,
	output logic [`EXU_XLEN-1:0] store_data,
	output logic                 jump_ena,
	output logic [`EXU_XLEN-1:0] jump_pc
);

	typedef enum logic [1:0] {st_idle, st_wait_unit, st_hold} state_e;

	state_e                    state;
	exu_op_pkg::exu_op_e       op_r;
	exu_op_pkg::op_class_e     in_cls;
	exu_op_pkg::op_class_e     op_cls_r;
	exu_csr_pkg::csr_cmd_e     csr_cmd;
	logic                      accept;
	logic                      start_q;
	logic                      is_trap;
	logic                      unit_done;
	logic [`EXU_XLEN-1:0]      op1_r;
	logic [`EXU_XLEN-1:0]      alu_res;
	logic [`EXU_XLEN-1:0]      csr_rdata;
	logic [`EXU_XLEN-1:0]      trap_pc;
	logic [`EXU_XLEN-1:0]      imm_res;
	logic [`EXU_XLEN-1:0]      unit_res;

	muldiv_if mul_bus ();
	muldiv_if div_bus ();

	assign out_valid = state == st_hold;
	assign ex_ready  = (state != st_wait_unit) && (!out_valid || ls_ready);
	assign accept    = in_valid && ex_ready;

	assign in_cls    = exu_op_pkg::op_class(op);
	assign op_cls_r  = exu_op_pkg::op_class(op_r);
	assign is_trap   = (op == exu_op_pkg::op_ecall) || (op == exu_op_pkg::op_mret);
	assign unit_done = mul_bus.done || div_bus.done;

	exu_alu i_exu_alu (
		.op  (op),
		.op1 (op1),
		.op2 (op2),
		.pc  (pc),
		.res (alu_res)
	);

	// CSR command only on the acceptance edge
	always_comb begin
		csr_cmd = exu_csr_pkg::csr_none;
		if (accept) begin
			case (op)
				exu_op_pkg::op_csrrw: csr_cmd = exu_csr_pkg::csr_write;
				exu_op_pkg::op_csrrs: csr_cmd = exu_csr_pkg::csr_set;
				exu_op_pkg::op_csrrc: csr_cmd = exu_csr_pkg::csr_clear;
				exu_op_pkg::op_ecall: csr_cmd = exu_csr_pkg::csr_ecall;
				exu_op_pkg::op_mret:  csr_cmd = exu_csr_pkg::csr_mret;
				default:              csr_cmd = exu_csr_pkg::csr_none;
			endcase
		end
	end

	exu_csr_file i_exu_csr_file (
		.clk     (clk),
		.reset   (reset),
		.cmd     (csr_cmd),
		.addr    (csr_addr),
		.wdata   (op1),
		.pc      (pc),
		.rdata   (csr_rdata),
		.trap_pc (trap_pc)
	);

	// single-cycle result, nop gives zero
	assign imm_res = (in_cls == exu_op_pkg::cls_csr) ? csr_rdata :
		(in_cls == exu_op_pkg::cls_alu) ? alu_res : '0;

	// requests use the operands registered at acceptance
	assign mul_bus.start = start_q && (op_cls_r == exu_op_pkg::cls_mul);
	assign mul_bus.op1   = op1_r;
	assign mul_bus.op2   = store_data;
	assign mul_bus.word  = op_r == exu_op_pkg::op_mulw;
	assign mul_bus.sgn   = (op_r == exu_op_pkg::op_mulhu)  ? 2'b00 :
		(op_r == exu_op_pkg::op_mulhsu) ? 2'b10 : 2'b11;

	assign div_bus.start = start_q && (op_cls_r == exu_op_pkg::cls_div);
	assign div_bus.op1   = op1_r;
	assign div_bus.op2   = store_data;
	assign div_bus.word  = (op_r == exu_op_pkg::op_divw) || (op_r == exu_op_pkg::op_divuw) ||
		(op_r == exu_op_pkg::op_remw) || (op_r == exu_op_pkg::op_remuw);
	assign div_bus.sgn   = {1'b0, (op_r == exu_op_pkg::op_div) || (op_r == exu_op_pkg::op_divw) ||
		(op_r == exu_op_pkg::op_rem) || (op_r == exu_op_pkg::op_remw)};

	exu_multiplier i_exu_multiplier (
		.clk   (clk),
		.reset (reset),
		.mul   (mul_bus.unit)
	);

	exu_divider i_exu_divider (
		.clk   (clk),
		.reset (reset),
		.div   (div_bus.unit)
	);

	// pick the half the opcode asks for
	always_comb begin
		case (op_r)
			exu_op_pkg::op_mul:
				unit_res = mul_bus.res_lo;
			exu_op_pkg::op_mulh, exu_op_pkg::op_mulhu, exu_op_pkg::op_mulhsu:
				unit_res = mul_bus.res_hi;
			exu_op_pkg::op_mulw:
				unit_res = {{(`EXU_XLEN-32){mul_bus.res_lo[31]}}, mul_bus.res_lo[31:0]};
			exu_op_pkg::op_div, exu_op_pkg::op_divu, exu_op_pkg::op_divw, exu_op_pkg::op_divuw:
				unit_res = div_bus.res_lo;
			default:
				unit_res = div_bus.res_hi;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= st_idle;
			op_r     <= exu_op_pkg::op_nop;
			start_q  <= 1'b0;
			jump_ena <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (accept) begin
				op_r     <= op;
				jump_ena <= is_trap;
				if (in_cls == exu_op_pkg::cls_mul || in_cls == exu_op_pkg::cls_div) begin
					state   <= st_wait_unit;
					start_q <= 1'b1;
				end else begin
					state <= st_hold;
				end
			end else if (state == st_hold && ls_ready) begin
				state <= st_idle;
			end else if (state == st_wait_unit && unit_done) begin
				state <= st_hold;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op1_r      <= op1;
			store_data <= op2;
			result     <= imm_res;
			jump_pc    <= trap_pc;
		end else if (state == st_wait_unit && unit_done) begin
			result <= unit_res;
		end
	end

	a_mul_start_idle: assert property (@(posedge clk) disable iff (reset)
		mul_bus.start |-> !mul_bus.busy);

	a_div_start_idle: assert property (@(posedge clk) disable iff (reset)
		div_bus.start |-> !div_bus.busy);

	// stalled output stays put until the load/store stage takes it
	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !ls_ready |=> out_valid && $stable(result) &&
			$stable(jump_ena) && $stable(jump_pc));

endmodule

/* verif/tb_exu.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module tb_exu;

	typedef logic [`EXU_XLEN-1:0] word_t;

	// instruction counts per test and the cycle limit derived from them
	localparam int N_ALU = 200;
	localparam int N_MUL_RAND = 8;
	localparam int N_MUL = 5 * (9 + N_MUL_RAND);
	localparam int N_DIV_RAND = 8;
	localparam int N_DIV = 8 * (4 + N_DIV_RAND);
	localparam int N_CSR = 22;
	localparam int N_TRAP = 10;
	localparam int N_BP = 60;
	localparam int TOTAL_OPS = N_ALU + N_MUL + N_DIV + N_CSR + N_TRAP + N_BP;
	localparam int CYCLE_LIMIT = TOTAL_OPS * 70 + 200;
	localparam word_t MIN_NEG = {1'b1, {(`EXU_XLEN-1){1'b0}}};

	logic                clk;
	logic                reset;
	logic                in_valid;
	exu_op_pkg::exu_op_e op;
	word_t               op1;
	word_t               op2;
	logic [11:0]         csr_addr;
	word_t               pc;
	logic                ls_ready;
	logic                ex_ready;
	logic                out_valid;
	word_t               result;
	word_t               store_data;
	logic                jump_ena;
	word_t               jump_pc;

	// shadow copy of the machine CSRs
	word_t sh_mstatus;
	word_t sh_mtvec;
	word_t sh_mepc;
	word_t sh_mcause;
	word_t sh_mscratch;

	// expected responses in issue order
	word_t exp_res_q[$];
	word_t exp_store_q[$];
	word_t exp_jpc_q[$];
	bit    exp_jena_q[$];
	string exp_name_q[$];

	int    errors;
	int    issued;
	int    received;
	int    pending;
	int    cycles;
	int    tests;
	bit    stalled;
	word_t held_result;
	logic  held_jena;
	bit    bp_on;
	bit    bp_pat [0:4095];
	int    bp_idx;

	exu_top i_exu_top (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.op         (op),
		.op1        (op1),
		.op2        (op2),
		.csr_addr   (csr_addr),
		.pc         (pc),
		.ls_ready   (ls_ready),
		.ex_ready   (ex_ready),
		.out_valid  (out_valid),
		.result     (result),
		.store_data (store_data),
		.jump_ena   (jump_ena),
		.jump_pc    (jump_pc)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	function automatic word_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic word_t sext32(input logic [31:0] v);
		return {{(`EXU_XLEN-32){v[31]}}, v};
	endfunction

	function automatic word_t csr_read(input logic [11:0] addr);
		case (addr)
			`EXU_CSR_MSTATUS:  return sh_mstatus;
			`EXU_CSR_MTVEC:    return sh_mtvec;
			`EXU_CSR_MEPC:     return sh_mepc;
			`EXU_CSR_MCAUSE:   return sh_mcause;
			`EXU_CSR_MSCRATCH: return sh_mscratch;
			default:           return '0;
		endcase
	endfunction

	function automatic void csr_write(input logic [11:0] addr, input word_t v);
		case (addr)
			`EXU_CSR_MSTATUS:  sh_mstatus = v;
			`EXU_CSR_MTVEC:    sh_mtvec = v;
			`EXU_CSR_MEPC:     sh_mepc = v;
			`EXU_CSR_MCAUSE:   sh_mcause = v;
			`EXU_CSR_MSCRATCH: sh_mscratch = v;
			default: begin
			end
		endcase
	endfunction

	// RISC-V division including divide by zero and signed overflow
	function automatic void divide(input word_t x, input word_t y, input bit s,
		output word_t q, output word_t r);
		if (y == '0) begin
			q = '1;
			r = x;
		end else if (s && x == MIN_NEG && y == '1) begin
			q = x;
			r = '0;
		end else if (s) begin
			q = $signed(x) / $signed(y);
			r = $signed(x) % $signed(y);
		end else begin
			q = x / y;
			r = x % y;
		end
	endfunction

	// expected result from the opcode rules and the shadow CSRs
	function automatic word_t exu_model(input exu_op_pkg::exu_op_e o, input word_t a,
		input word_t b, input word_t p, input logic [11:0] addr);
		logic [2*`EXU_XLEN-1:0] ea;
		logic [2*`EXU_XLEN-1:0] eb;
		logic [2*`EXU_XLEN-1:0] prod;
		word_t q;
		word_t r;
		ea = {{`EXU_XLEN{a[`EXU_XLEN-1]}}, a};
		eb = {{`EXU_XLEN{b[`EXU_XLEN-1]}}, b};
		if (o == exu_op_pkg::op_mulhu)
			ea = {{`EXU_XLEN{1'b0}}, a};
		if (o == exu_op_pkg::op_mulhu || o == exu_op_pkg::op_mulhsu)
			eb = {{`EXU_XLEN{1'b0}}, b};
		prod = ea * eb;
		case (o)
			exu_op_pkg::op_div, exu_op_pkg::op_rem:
				divide(a, b, 1'b1, q, r);
			exu_op_pkg::op_divu, exu_op_pkg::op_remu:
				divide(a, b, 1'b0, q, r);
			exu_op_pkg::op_divw, exu_op_pkg::op_remw:
				divide(sext32(a[31:0]), sext32(b[31:0]), 1'b1, q, r);
			default:
				divide({32'b0, a[31:0]}, {32'b0, b[31:0]}, 1'b0, q, r);
		endcase
		case (o)
			exu_op_pkg::op_add:  return a + b;
			exu_op_pkg::op_sub:  return a - b;
			exu_op_pkg::op_xor:  return a ^ b;
			exu_op_pkg::op_or:   return a | b;
			exu_op_pkg::op_and:  return a & b;
			exu_op_pkg::op_slt:  return word_t'($signed(a) < $signed(b));
			exu_op_pkg::op_sltu: return word_t'(a < b);
			exu_op_pkg::op_sll:  return a << b[5:0];
			exu_op_pkg::op_srl:  return a >> b[5:0];
			exu_op_pkg::op_sra:  return $signed(a) >>> b[5:0];
			exu_op_pkg::op_addw: return sext32(a[31:0] + b[31:0]);
			exu_op_pkg::op_subw: return sext32(a[31:0] - b[31:0]);
			exu_op_pkg::op_sllw: return sext32(a[31:0] << b[4:0]);
			exu_op_pkg::op_srlw: return sext32(a[31:0] >> b[4:0]);
			exu_op_pkg::op_sraw: return sext32($signed(a[31:0]) >>> b[4:0]);
			exu_op_pkg::op_link: return p + 4;
			exu_op_pkg::op_mul:  return prod[`EXU_XLEN-1:0];
			exu_op_pkg::op_mulh, exu_op_pkg::op_mulhu, exu_op_pkg::op_mulhsu:
				return prod[2*`EXU_XLEN-1:`EXU_XLEN];
			exu_op_pkg::op_mulw: return sext32(prod[31:0]);
			exu_op_pkg::op_div, exu_op_pkg::op_divu: return q;
			exu_op_pkg::op_rem, exu_op_pkg::op_remu: return r;
			exu_op_pkg::op_divw, exu_op_pkg::op_divuw: return sext32(q[31:0]);
			exu_op_pkg::op_remw, exu_op_pkg::op_remuw: return sext32(r[31:0]);
			exu_op_pkg::op_csrrw, exu_op_pkg::op_csrrs, exu_op_pkg::op_csrrc,
			exu_op_pkg::op_ecall, exu_op_pkg::op_mret:
				return csr_read(addr);
			default: return '0;
		endcase
	endfunction

	function automatic void csr_update(input exu_op_pkg::exu_op_e o, input word_t a,
		input word_t p, input logic [11:0] addr);
		case (o)
			exu_op_pkg::op_csrrw: csr_write(addr, a);
			exu_op_pkg::op_csrrs: csr_write(addr, csr_read(addr) | a);
			exu_op_pkg::op_csrrc: csr_write(addr, csr_read(addr) & ~a);
			exu_op_pkg::op_ecall: begin
				sh_mepc = p;
				sh_mcause = `EXU_CAUSE_ECALL_M;
			end
			default: begin
			end
		endcase
	endfunction

	// drive one instruction on a falling edge and wait until it is taken
	task automatic issue(input exu_op_pkg::exu_op_e o, input word_t a, input word_t b,
		input logic [11:0] addr, input word_t p, input string tag);
		exu_op_pkg::op_class_e cls;
		cls = exu_op_pkg::op_class(o);
		exp_res_q.push_back(exu_model(o, a, b, p, addr));
		exp_store_q.push_back(b);
		exp_jena_q.push_back(o == exu_op_pkg::op_ecall || o == exu_op_pkg::op_mret);
		exp_jpc_q.push_back(o == exu_op_pkg::op_ecall ? sh_mtvec : sh_mepc);
		exp_name_q.push_back(tag);
		csr_update(o, a, p, addr);
		pending++;
		issued++;
		in_valid = 1'b1;
		op = o;
		op1 = a;
		op2 = b;
		csr_addr = addr;
		pc = p;
		do
			@(posedge clk);
		while (!ex_ready);
		@(negedge clk);
		in_valid = 1'b0;
		// stage must stall until the unit result is out
		if (cls == exu_op_pkg::cls_mul || cls == exu_op_pkg::cls_div) begin
			while (!out_valid) begin
				check_value({tag, " ex_ready"}, '0, word_t'(ex_ready));
				@(negedge clk);
			end
		end
	endtask

	task automatic finish_test(input string name, input int err0, input int n0);
		wait (pending == 0);
		@(negedge clk);
		tests++;
		$display("test %s: %0d instructions, %0d errors", name, issued - n0, errors - err0);
	endtask

	task automatic alu_ops();
		int err0;
		int n0;
		int k;
		exu_op_pkg::exu_op_e o;
		word_t a;
		word_t b;
		err0 = errors;
		n0 = issued;
		for (int i = 0; i < N_ALU; i++) begin
			k = $urandom % 17;
			o = (k == 16) ? exu_op_pkg::op_nop : exu_op_pkg::exu_op_e'(k);
			a = rand64();
			b = rand64();
			// force mixed signs now and then
			if (i % 4 == 0) begin
				a[`EXU_XLEN-1] = 1'b1;
				b[`EXU_XLEN-1] = 1'b0;
			end
			issue(o, a, b, '0, rand64(), $sformatf("%s #%0d", o.name(), i));
		end
		finish_test("integer", err0, n0);
	endtask

	task automatic mul_ops();
		exu_op_pkg::exu_op_e ops [5];
		word_t edge_val [3];
		int err0;
		int n0;
		err0 = errors;
		n0 = issued;
		ops = '{exu_op_pkg::op_mul, exu_op_pkg::op_mulh, exu_op_pkg::op_mulhu,
			exu_op_pkg::op_mulhsu, exu_op_pkg::op_mulw};
		edge_val = '{'0, '1, MIN_NEG};
		foreach (ops[j]) begin
			for (int x = 0; x < 3; x++)
				for (int y = 0; y < 3; y++)
					issue(ops[j], edge_val[x], edge_val[y], '0, '0,
						$sformatf("%s edge %0d/%0d", ops[j].name(), x, y));
			for (int i = 0; i < N_MUL_RAND; i++)
				issue(ops[j], rand64(), rand64(), '0, '0, $sformatf("%s #%0d", ops[j].name(), i));
		end
		finish_test("multiply", err0, n0);
	endtask

	task automatic div_ops();
		exu_op_pkg::exu_op_e ops [8];
		int err0;
		int n0;
		err0 = errors;
		n0 = issued;
		ops = '{exu_op_pkg::op_div, exu_op_pkg::op_divu, exu_op_pkg::op_divw,
			exu_op_pkg::op_divuw, exu_op_pkg::op_rem, exu_op_pkg::op_remu,
			exu_op_pkg::op_remw, exu_op_pkg::op_remuw};
		foreach (ops[j]) begin
			issue(ops[j], rand64(), '0, '0, '0, $sformatf("%s by zero", ops[j].name()));
			issue(ops[j], MIN_NEG, '1, '0, '0, $sformatf("%s overflow", ops[j].name()));
			issue(ops[j], {$urandom, 32'h8000_0000}, '1, '0, '0,
				$sformatf("%s word overflow", ops[j].name()));
			issue(ops[j], rand64(), word_t'($urandom % 1000 + 1), '0, '0,
				$sformatf("%s small divisor", ops[j].name()));
			for (int i = 0; i < N_DIV_RAND; i++)
				issue(ops[j], rand64(), rand64(), '0, '0, $sformatf("%s #%0d", ops[j].name(), i));
		end
		finish_test("divide", err0, n0);
	endtask

	task automatic csr_ops();
		logic [11:0] addrs [5];
		int err0;
		int n0;
		err0 = errors;
		n0 = issued;
		addrs = '{`EXU_CSR_MSTATUS, `EXU_CSR_MTVEC, `EXU_CSR_MEPC, `EXU_CSR_MCAUSE,
			`EXU_CSR_MSCRATCH};
		foreach (addrs[j]) begin
			issue(exu_op_pkg::op_csrrw, rand64(), '0, addrs[j], '0, $sformatf("csrrw %h", addrs[j]));
			issue(exu_op_pkg::op_csrrs, rand64(), '0, addrs[j], '0, $sformatf("csrrs %h", addrs[j]));
			issue(exu_op_pkg::op_csrrc, rand64(), '0, addrs[j], '0, $sformatf("csrrc %h", addrs[j]));
			issue(exu_op_pkg::op_csrrs, '0, '0, addrs[j], '0, $sformatf("read %h", addrs[j]));
		end
		// unknown address
		issue(exu_op_pkg::op_csrrw, rand64(), '0, 12'h7c0, '0, "csrrw unknown");
		issue(exu_op_pkg::op_csrrs, '0, '0, 12'h7c0, '0, "read unknown");
		finish_test("csr", err0, n0);
	endtask

	task automatic trap_ops();
		word_t ecall_pc;
		int err0;
		int n0;
		err0 = errors;
		n0 = issued;
		for (int i = 0; i < 2; i++) begin
			ecall_pc = rand64() & ~word_t'(3);
			issue(exu_op_pkg::op_csrrw, rand64() & ~word_t'(3), '0, `EXU_CSR_MTVEC, '0,
				"set mtvec");
			issue(exu_op_pkg::op_ecall, '0, '0, `EXU_CSR_MCAUSE, ecall_pc, "ecall");
			issue(exu_op_pkg::op_csrrs, '0, '0, `EXU_CSR_MCAUSE, '0, "read mcause");
			issue(exu_op_pkg::op_csrrs, '0, '0, `EXU_CSR_MEPC, '0, "read mepc");
			issue(exu_op_pkg::op_mret, '0, '0, `EXU_CSR_MEPC, rand64(), "mret");
		end
		finish_test("trap", err0, n0);
	endtask

	task automatic stall_ops();
		exu_op_pkg::exu_op_e o;
		bit level;
		int len;
		int idx;
		int err0;
		int n0;
		err0 = errors;
		n0 = issued;
		// ls_ready pattern in random stretches of one to eight cycles
		idx = 0;
		while (idx < 4096) begin
			level = bit'($urandom % 2);
			len = 1 + $urandom % 8;
			for (int k = 0; k < len && idx < 4096; k++) begin
				bp_pat[idx] = level;
				idx++;
			end
		end
		bp_idx = 0;
		bp_on = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			o = exu_op_pkg::exu_op_e'($urandom % 29);
			repeat ($urandom % 3) @(negedge clk);
			issue(o, rand64(), rand64(), '0, rand64(), $sformatf("bp %s #%0d", o.name(), i));
		end
		finish_test("backpressure", err0, n0);
		bp_on = 1'b0;
	endtask

	always @(negedge clk) begin
		if (bp_on) begin
			ls_ready = bp_pat[bp_idx % 4096];
			bp_idx++;
		end else begin
			ls_ready = 1'b1;
		end
	end

	// compares every result taken by the load/store stage
	always @(posedge clk) begin
		if (!reset) begin
			if (stalled) begin
				if (!out_valid) begin
					$display("out_valid dropped while ls_ready was low");
					errors++;
				end else begin
					check_value("hold result", held_result, result);
					check_value("hold jump_ena", word_t'(held_jena), word_t'(jump_ena));
				end
			end
			stalled = 1'b0;
			if (out_valid && !ls_ready) begin
				stalled = 1'b1;
				held_result = result;
				held_jena = jump_ena;
			end
			if (out_valid && ls_ready) begin
				received++;
				if (pending == 0) begin
					$display("result appeared with no instruction pending");
					errors++;
				end else begin
					check_value({exp_name_q[0], " result"}, exp_res_q[0], result);
					check_value({exp_name_q[0], " store_data"}, exp_store_q[0], store_data);
					check_value({exp_name_q[0], " jump_ena"}, word_t'(exp_jena_q[0]),
						word_t'(jump_ena));
					if (exp_jena_q[0])
						check_value({exp_name_q[0], " jump_pc"}, exp_jpc_q[0], jump_pc);
					void'(exp_res_q.pop_front());
					void'(exp_store_q.pop_front());
					void'(exp_jena_q.pop_front());
					void'(exp_jpc_q.pop_front());
					void'(exp_name_q.pop_front());
					pending--;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		op = exu_op_pkg::op_nop;
		op1 = '0;
		op2 = '0;
		csr_addr = '0;
		pc = '0;
		ls_ready = 1'b1;
		bp_on = 1'b0;
		bp_idx = 0;
		stalled = 1'b0;
		errors = 0;
		issued = 0;
		received = 0;
		pending = 0;
		tests = 0;
		sh_mstatus = '0;
		sh_mtvec = '0;
		sh_mepc = '0;
		sh_mcause = '0;
		sh_mscratch = '0;
		void'($urandom(31987));
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		alu_ops();
		mul_ops();
		div_ops();
		csr_ops();
		trap_ops();
		stall_ops();
		repeat (4) @(negedge clk);
		if (received != issued) begin
			$display("issued %0d instructions but %0d results came out", issued, received);
			errors++;
		end
		$display("%0d tests, %0d issued, %0d results, %0d errors", tests, issued, received,
			errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
hdl/exu_op_pkg.sv
hdl/exu_csr_pkg.sv
hdl/muldiv_if.sv
hdl/exu_alu.sv
hdl/exu_multiplier.sv
hdl/exu_divider.sv
hdl/exu_csr_file.sv
hdl/exu_top.sv
verif/tb_exu.sv
